// File: src/pss_pkg.sv
`default_nettype none

package pss_pkg;

    // -------------------------------------------------------------------------
    // widths
    // -------------------------------------------------------------------------

    localparam int IQ_DW     = 8;
    localparam int PSS_LEN   = 16;
    localparam int N_SEQ     = 3;

    // full-scale sum of PSS_LEN samples needs log2(PSS_LEN) + 1 extra bits
    localparam int CORR_DW   = IQ_DW + $clog2(PSS_LEN) + 1;
    localparam int METRIC_DW = CORR_DW + 1;

    // window fill counter, counts 0 .. PSS_LEN
    localparam int FILL_W    = $clog2(PSS_LEN + 1);

    localparam logic [METRIC_DW-1:0] DETECT_THRESHOLD = METRIC_DW'(1200);

    // -------------------------------------------------------------------------
    // local PSS chip patterns, bit j applies to window element j
    // -------------------------------------------------------------------------

    // 1 is +1, 0 is -1
    localparam logic [PSS_LEN-1:0] PSS_TAPS [0:N_SEQ-1] = '{
        16'h9ae3,
        16'h4d72,
        16'he25b
    };

    // -------------------------------------------------------------------------
    // types
    // -------------------------------------------------------------------------

    typedef struct packed {
        logic signed [IQ_DW-1:0] re;
        logic signed [IQ_DW-1:0] im;
    } iq_t;

    // element 0 is the newest sample
    typedef iq_t [PSS_LEN-1:0] window_t;

    typedef struct packed {
        logic [METRIC_DW-1:0] metric;
        logic                 valid;
    } metric_t;

    typedef struct packed {
        logic                 valid;
        logic [1:0]           n_id_2;
        logic [METRIC_DW-1:0] metric;
    } detect_t;

    typedef enum logic [0:0] {
        P_IDLE,
        P_REPORT
    } picker_state_e;

endpackage

`default_nettype wire

// File: src/sample_window.sv
`timescale 1ns/1ps
`default_nettype none

module sample_window (
    input  wire logic             clk_i,
    input  wire logic             reset_ni,
    input  wire pss_pkg::iq_t     sample_i,
    input  wire logic             sample_valid_i,
    output pss_pkg::window_t      win_o,
    output logic                  win_valid_o
);

    logic [pss_pkg::FILL_W-1:0] fill_q;
    logic                       fills_now;
    logic                       is_full;

    assign is_full   = (fill_q == pss_pkg::FILL_W'(pss_pkg::PSS_LEN));
    // the current strobe completes or refreshes a full window
    assign fills_now = (fill_q >= pss_pkg::FILL_W'(pss_pkg::PSS_LEN - 1));

    // -------------------------------------------------------------------------
    // shift register, newest sample in element 0
    // -------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (sample_valid_i) begin
            win_o[pss_pkg::PSS_LEN-1:1] <= win_o[pss_pkg::PSS_LEN-2:0];
            win_o[0]                    <= sample_i;
        end
    end

    // -------------------------------------------------------------------------
    // fill count and window strobe
    // -------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            fill_q      <= '0;
            win_valid_o <= 1'b0;
        end else begin
            win_valid_o <= sample_valid_i && fills_now;
            // saturate once full
            if (sample_valid_i && !is_full) begin
                fill_q <= fill_q + 1'b1;
            end
        end
    end

    a_fill_bound : assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        fill_q <= pss_pkg::FILL_W'(pss_pkg::PSS_LEN)
    ) else $error("sample window fill count above PSS_LEN");

endmodule

`default_nettype wire

// File: src/pss_correlator.sv
`timescale 1ns/1ps
`default_nettype none

module pss_correlator #(
    parameter int N_ID_2 = 0
) (
    input  wire logic              clk_i,
    input  wire logic              reset_ni,
    input  wire pss_pkg::window_t  win_i,
    input  wire logic              win_valid_i,
    output pss_pkg::metric_t       metric_o
);

    logic signed [pss_pkg::CORR_DW-1:0]  re_sum;
    logic signed [pss_pkg::CORR_DW-1:0]  im_sum;
    logic signed [pss_pkg::CORR_DW-1:0]  re_sum_q;
    logic signed [pss_pkg::CORR_DW-1:0]  im_sum_q;
    logic                                sum_valid_q;

    logic        [pss_pkg::CORR_DW-1:0]  re_abs;
    logic        [pss_pkg::CORR_DW-1:0]  im_abs;
    logic        [pss_pkg::METRIC_DW-1:0] metric_q;
    logic                                metric_valid_q;

    // -------------------------------------------------------------------------
    // stage 1: signed chip sums
    // -------------------------------------------------------------------------

    always_comb begin
        re_sum = '0;
        im_sum = '0;
        for (int j = 0; j < pss_pkg::PSS_LEN; j++) begin
            if (pss_pkg::PSS_TAPS[N_ID_2][j]) begin
                re_sum = re_sum + pss_pkg::CORR_DW'(win_i[j].re);
                im_sum = im_sum + pss_pkg::CORR_DW'(win_i[j].im);
            end else begin
                re_sum = re_sum - pss_pkg::CORR_DW'(win_i[j].re);
                im_sum = im_sum - pss_pkg::CORR_DW'(win_i[j].im);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        re_sum_q <= re_sum;
        im_sum_q <= im_sum;
    end

    // -------------------------------------------------------------------------
    // stage 2: |re| + |im|
    // -------------------------------------------------------------------------

    // -2048 still fits as unsigned 13 bit magnitude
    assign re_abs = re_sum_q[pss_pkg::CORR_DW-1] ? -re_sum_q : re_sum_q;
    assign im_abs = im_sum_q[pss_pkg::CORR_DW-1] ? -im_sum_q : im_sum_q;

    always_ff @(posedge clk_i) begin
        metric_q <= pss_pkg::METRIC_DW'(re_abs) + pss_pkg::METRIC_DW'(im_abs);
    end

    // valid follows the data through both stages
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sum_valid_q    <= 1'b0;
            metric_valid_q <= 1'b0;
        end else begin
            sum_valid_q    <= win_valid_i;
            metric_valid_q <= sum_valid_q;
        end
    end

    assign metric_o = '{metric: metric_q, valid: metric_valid_q};

endmodule

`default_nettype wire

// File: src/peak_picker.sv
`timescale 1ns/1ps
`default_nettype none

module peak_picker (
    input  wire logic                                      clk_i,
    input  wire logic                                      reset_ni,
    input  wire pss_pkg::metric_t [pss_pkg::N_SEQ-1:0]     metrics_i,
    output pss_pkg::detect_t                               detect_o
);

    logic [pss_pkg::N_SEQ-1:0]     valid_vec;
    logic [1:0]                    best_idx;
    logic [pss_pkg::METRIC_DW-1:0] best_metric;
    logic                          hit;

    pss_pkg::picker_state_e        state_q;
    pss_pkg::picker_state_e        state_d;
    logic [1:0]                    det_idx_q;
    logic [pss_pkg::METRIC_DW-1:0] det_metric_q;

    always_comb begin
        for (int k = 0; k < pss_pkg::N_SEQ; k++) begin
            valid_vec[k] = metrics_i[k].valid;
        end
    end

    // -------------------------------------------------------------------------
    // maximum search, strict compare keeps the lowest index on a tie
    // -------------------------------------------------------------------------

    always_comb begin
        best_idx    = '0;
        best_metric = metrics_i[0].metric;
        for (int k = 1; k < pss_pkg::N_SEQ; k++) begin
            if (metrics_i[k].metric > best_metric) begin
                best_metric = metrics_i[k].metric;
                best_idx    = 2'(k);
            end
        end
    end

    // all correlators share one pipeline, so valid 0 stands for the set
    assign hit = valid_vec[0] && (best_metric >= pss_pkg::DETECT_THRESHOLD);

    // -------------------------------------------------------------------------
    // report FSM
    // -------------------------------------------------------------------------

    // every hit reports for one cycle, back-to-back hits keep P_REPORT
    always_comb begin
        state_d = hit ? pss_pkg::P_REPORT : pss_pkg::P_IDLE;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= pss_pkg::P_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (hit) begin
            det_idx_q    <= best_idx;
            det_metric_q <= best_metric;
        end
    end

    assign detect_o = '{
        valid:  (state_q == pss_pkg::P_REPORT),
        n_id_2: det_idx_q,
        metric: det_metric_q
    };

    a_valid_agree : assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        (valid_vec == '0) || (valid_vec == '1)
    ) else $error("correlator valids out of step");

    a_report_threshold : assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        detect_o.valid |-> (detect_o.metric >= pss_pkg::DETECT_THRESHOLD)
    ) else $error("detection reported below threshold");

endmodule

`default_nettype wire

// File: src/pss_detector.sv
`timescale 1ns/1ps
`default_nettype none

module pss_detector (
    input  wire logic           clk_i,
    input  wire logic           reset_ni,
    input  wire pss_pkg::iq_t   sample_i,
    input  wire logic           sample_valid_i,
    output pss_pkg::detect_t    detect_o
);

    pss_pkg::window_t                        win;
    logic                                    win_valid;
    pss_pkg::metric_t [pss_pkg::N_SEQ-1:0]   metrics;

    // -------------------------------------------------------------------------
    // sample window, 1 cycle
    // -------------------------------------------------------------------------

    sample_window u_window (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .win_o          (win),
        .win_valid_o    (win_valid)
    );

    // -------------------------------------------------------------------------
    // one correlator per N_id_2, 2 cycles
    // -------------------------------------------------------------------------

    for (genvar k = 0; k < pss_pkg::N_SEQ; k++) begin : g_corr
        pss_correlator #(
            .N_ID_2 (k)
        ) u_corr (
            .clk_i       (clk_i),
            .reset_ni    (reset_ni),
            .win_i       (win),
            .win_valid_i (win_valid),
            .metric_o    (metrics[k])
        );
    end

    // peak picker, 1 cycle
    peak_picker u_picker (
        .clk_i     (clk_i),
        .reset_ni  (reset_ni),
        .metrics_i (metrics),
        .detect_o  (detect_o)
    );

endmodule

`default_nettype wire

// File: verification/pss_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pss_checker (
    input  wire logic             clk_i,
    input  wire logic             reset_ni,
    input  wire logic             sample_valid_i,
    input  wire logic [15:0]      case_idx_i,
    input  wire pss_pkg::detect_t expected_i,
    input  wire pss_pkg::detect_t detect_i,
    output logic [31:0]           error_count_o,
    output logic [31:0]           check_count_o
);

    // strobe to detect_o is 4 rising edges
    // slot 0 is taken on the falling edge before the first of them
    localparam int LATENCY  = 4;
    localparam int CHECK_AT = LATENCY;
    localparam int DEPTH    = CHECK_AT + 1;

    logic [DEPTH-1:0] pend_valid;
    logic [15:0]      pend_idx [DEPTH];
    pss_pkg::detect_t pend_exp [DEPTH];

    initial begin
        pend_valid    = '0;
        error_count_o = '0;
        check_count_o = '0;
    end

    always @(negedge clk_i) begin
        for (int i = DEPTH - 1; i > 0; i--) begin
            pend_valid[i] = pend_valid[i-1];
            pend_idx[i]   = pend_idx[i-1];
            pend_exp[i]   = pend_exp[i-1];
        end
        pend_valid[0] = sample_valid_i && reset_ni;
        pend_idx[0]   = case_idx_i;
        pend_exp[0]   = expected_i;

        if (reset_ni === 1'b1) begin
            check_count_o++;
            if (pend_valid[CHECK_AT] && pend_exp[CHECK_AT].valid) begin
                if (detect_i.valid !== 1'b1) begin
                    $display("case %0d: the expected detection did not arrive",
                             pend_idx[CHECK_AT]);
                    error_count_o++;
                end else begin
                    if (detect_i.n_id_2 !== pend_exp[CHECK_AT].n_id_2) begin
                        $display("** Error detect_o.n_id_2 (case %0d): expected 0x%h, got 0x%h",
                                 pend_idx[CHECK_AT], pend_exp[CHECK_AT].n_id_2,
                                 detect_i.n_id_2);
                        error_count_o++;
                    end
                    if (detect_i.metric !== pend_exp[CHECK_AT].metric) begin
                        $display("** Error detect_o.metric (case %0d): expected 0x%h, got 0x%h",
                                 pend_idx[CHECK_AT], pend_exp[CHECK_AT].metric,
                                 detect_i.metric);
                        error_count_o++;
                    end
                end
            end else if (detect_i.valid !== 1'b0) begin
                // either a silent case or no strobe at all in that slot
                $display("detection reported at %0t where none was expected", $time);
                error_count_o++;
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_pss_detector.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pss_detector;

    localparam int          CLK_PERIOD     = 10;
    localparam int          FIELDS         = 6;
    localparam int          MAX_CASES      = 256;
    localparam int          TIMEOUT_MARGIN = 50;
    localparam int          DRAIN_CYCLES   = 6;
    localparam logic [31:0] SEED           = 32'hd2c3_ca0c;

    // control column of the cases file
    localparam logic [15:0] CTL_GAP   = 16'h0001;
    localparam logic [15:0] CTL_RESET = 16'h0002;
    localparam logic [15:0] CTL_END   = 16'h000f;

    logic             clk = 1'b0;
    logic             reset_n;
    pss_pkg::iq_t     sample;
    logic             sample_valid;
    pss_pkg::detect_t detect;

    logic [15:0]      case_idx;
    pss_pkg::detect_t exp_detect;
    logic [31:0]      error_count;
    logic [31:0]      check_count;

    logic [15:0]      cases [0:MAX_CASES*FIELDS-1];
    int               num_cases;
    int               cycle_count = 0;
    int               timeout_limit = 0;

    always #(CLK_PERIOD/2) clk = ~clk;

    pss_detector u_dut (
        .clk_i          (clk),
        .reset_ni       (reset_n),
        .sample_i       (sample),
        .sample_valid_i (sample_valid),
        .detect_o       (detect)
    );

    pss_checker u_checker (
        .clk_i          (clk),
        .reset_ni       (reset_n),
        .sample_valid_i (sample_valid),
        .case_idx_i     (case_idx),
        .expected_i     (exp_detect),
        .detect_i       (detect),
        .error_count_o  (error_count),
        .check_count_o  (check_count)
    );

    // ------------------------------------------------------------------------
    // run limit
    // ------------------------------------------------------------------------

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("checks: %0d, errors: %0d", check_count, error_count);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic apply_reset();
        reset_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset_n = 1'b1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the next one
    task automatic drive_case(input int idx);
        logic [15:0] ctl;
        int          gap;
        ctl = cases[idx*FIELDS];
        if (ctl == CTL_RESET) begin
            // let detections in flight come out before the reset
            idle_cycles(DRAIN_CYCLES);
            apply_reset();
        end else if (ctl == CTL_GAP) begin
            gap = $urandom % 3;
            idle_cycles(gap);
        end
        sample.re         = cases[idx*FIELDS+1][7:0];
        sample.im         = cases[idx*FIELDS+2][7:0];
        exp_detect.valid  = cases[idx*FIELDS+3][0];
        exp_detect.n_id_2 = cases[idx*FIELDS+4][1:0];
        exp_detect.metric = cases[idx*FIELDS+5][pss_pkg::METRIC_DW-1:0];
        case_idx          = 16'(idx);
        sample_valid      = 1'b1;
        @(posedge clk);
        #1;
        sample_valid = 1'b0;
    endtask

    initial begin
        reset_n      = 1'b0;
        sample       = '0;
        sample_valid = 1'b0;
        case_idx     = '0;
        exp_detect   = '0;
        void'($urandom(SEED));

        $readmemh("verification/pss_cases.mem", cases);
        num_cases = 0;
        while (num_cases < MAX_CASES && cases[num_cases*FIELDS] !== CTL_END) begin
            num_cases++;
        end
        timeout_limit = num_cases * 3 + TIMEOUT_MARGIN;
        $display("%0d cases, limit %0d cycles", num_cases, timeout_limit);

        repeat (2) @(posedge clk);
        #1;
        reset_n = 1'b1;

        for (int i = 0; i < num_cases; i++) begin
            drive_case(i);
        end
        idle_cycles(DRAIN_CYCLES + 2);

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/pss_cases.mem
// columns: ctl I Q det n_id_2 metric
// ctl 0 next cycle, 1 random gap of 0..2 cycles, 2 reset first, f end of cases
// ---------------------------------------------------------------------------
// N_id_2 0 from reset on consecutive cycles, then 4 zeros
0 64 00 0 0 000
0 9c 00 0 0 000
0 9c 00 0 0 000
0 64 00 0 0 000
0 64 00 0 0 000
0 9c 00 0 0 000
0 64 00 0 0 000
0 9c 00 0 0 000
0 64 00 0 0 000
0 64 00 0 0 000
0 64 00 0 0 000
0 9c 00 0 0 000
0 9c 00 0 0 000
0 9c 00 0 0 000
0 64 00 0 0 000
0 64 00 1 0 640
0 00 00 0 0 000
0 00 00 0 0 000
0 00 00 0 0 000
0 00 00 0 0 000
// N_id_2 1
2 9c 00 0 0 000
0 64 00 0 0 000
0 9c 00 0 0 000
0 9c 00 0 0 000
0 64 00 0 0 000
0 64 00 0 0 000
0 9c 00 0 0 000
0 64 00 0 0 000
0 9c 00 0 0 000
0 64 00 0 0 000
0 64 00 0 0 000
0 64 00 0 0 000
0 9c 00 0 0 000
0 9c 00 0 0 000
0 64 00 0 0 000
0 9c 00 1 1 640
// N_id_2 2
2 64 00 0 0 000
0 64 00 0 0 000
0 64 00 0 0 000
0 9c 00 0 0 000
0 9c 00 0 0 000
0 9c 00 0 0 000
0 64 00 0 0 000
0 9c 00 0 0 000
0 9c 00 0 0 000
0 64 00 0 0 000
0 9c 00 0 0 000
0 64 00 0 0 000
0 64 00 0 0 000
0 9c 00 0 0 000
0 64 00 0 0 000
0 64 00 1 2 640
// N_id_2 1 at amplitude 70 with small noise on Q, 1120 plus at most 32
2 ba 02 0 0 000
0 46 fe 0 0 000
0 ba 01 0 0 000
0 ba ff 0 0 000
0 46 02 0 0 000
0 46 fe 0 0 000
0 ba 01 0 0 000
0 46 ff 0 0 000
0 ba 02 0 0 000
0 46 fe 0 0 000
0 46 01 0 0 000
0 46 ff 0 0 000
0 ba 02 0 0 000
0 ba fe 0 0 000
0 46 01 0 0 000
0 ba ff 0 0 000
// N_id_2 0 with random gaps
2 64 00 0 0 000
1 9c 00 0 0 000
1 9c 00 0 0 000
1 64 00 0 0 000
1 64 00 0 0 000
1 9c 00 0 0 000
1 64 00 0 0 000
1 9c 00 0 0 000
1 64 00 0 0 000
1 64 00 0 0 000
1 64 00 0 0 000
1 9c 00 0 0 000
1 9c 00 0 0 000
1 9c 00 0 0 000
1 64 00 0 0 000
1 64 00 1 0 640
1 00 00 0 0 000
1 00 00 0 0 000
// N_id_2 2 split by a reset after 10 chips, then zeros to refill
2 64 00 0 0 000
0 64 00 0 0 000
0 64 00 0 0 000
0 9c 00 0 0 000
0 9c 00 0 0 000
0 9c 00 0 0 000
0 64 00 0 0 000
0 9c 00 0 0 000
0 9c 00 0 0 000
0 64 00 0 0 000
2 9c 00 0 0 000
0 64 00 0 0 000
0 64 00 0 0 000
0 9c 00 0 0 000
0 64 00 0 0 000
0 64 00 0 0 000
0 00 00 0 0 000
0 00 00 0 0 000
0 00 00 0 0 000
0 00 00 0 0 000
0 00 00 0 0 000
0 00 00 0 0 000
0 00 00 0 0 000
0 00 00 0 0 000
0 00 00 0 0 000
0 00 00 0 0 000
f 00 00 0 0 000

// File: sim.f
src/pss_pkg.sv
src/sample_window.sv
src/pss_correlator.sv
src/peak_picker.sv
src/pss_detector.sv
verification/pss_checker.sv
verification/tb_pss_detector.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_pss_detector
FILELIST  := sim.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee /dev/stderr | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
